/* rtl/tv80_defs.svh */
//--------------------------------------------------------------------------
// Shared constants of the reduced TV80 core
//   Reset values of PC, accumulator and flags
//   Default prefetch queue depth
//   Opcodes and opcode groups of the kept instruction subset
//--------------------------------------------------------------------------

`ifndef TV80_DEFS_SVH
`define TV80_DEFS_SVH

`define RESET_PC       16'h0000
`define RESET_ACC      8'hFF
`define RESET_FLAGS    8'hFF   // S Z Y H X P/V N C all set

`define QUEUE_DEPTH    4

// Single opcodes
`define OP_NOP         8'h00
`define OP_HALT        8'h76
`define OP_LD_A_N      8'h3E
`define OP_CPL         8'h2F
`define OP_SCF         8'h37
`define OP_CCF         8'h3F
`define OP_JP          8'hC3
`define OP_ST_A        8'h32   // LD (nn),A
`define OP_LD_A_MEM    8'h3A   // LD A,(nn)

// Opcode groups, bits 5:3 select the ALU op or the condition
`define OP_GROUP_MASK  8'hC7
`define OP_ALU_N       8'hC6
`define OP_JP_CC       8'hC2

`endif

/* rtl/tv80Pkg.sv */
//--------------------------------------------------------------------------
// Types of the reduced TV80 core
//   Byte and address vectors, flag register layout
//   ALU operation and execute state enums
//   Wishbone request/response, queue entry and redirect structs
//--------------------------------------------------------------------------

package tv80Pkg;

  typedef logic [7:0]  dataByte;
  typedef logic [15:0] codeAddr;

  // Z80 flag register, bit 7 down to bit 0
  typedef struct packed {
    logic s;
    logic z;
    logic y;
    logic h;
    logic x;
    logic pv;
    logic n;
    logic c;
  } flagSet;

  // Encoding follows bits 5:3 of the immediate ALU opcodes
  typedef enum logic [2:0] {
    aluAdd, aluAdc, aluSub, aluSbc, aluAnd, aluXor, aluOr, aluCp
  } aluOp;

  typedef enum logic [2:0] {
    stOpcode, stImmediate, stAddrLow, stAddrHigh, stMemRead, stMemWrite, stHalted
  } execState;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    codeAddr adr;
    dataByte datOut;
  } wbReq;

  typedef struct packed {
    logic    ack;
    dataByte datIn;
  } wbRsp;

  typedef struct packed {
    dataByte data;
    codeAddr addr;     // PC of this byte
  } queueEntry;

  typedef struct packed {
    logic    valid;
    codeAddr target;
  } redirect;

endpackage

/* rtl/tv80Alu.sv */
//--------------------------------------------------------------------------
// 8-bit ALU for the immediate operations
//   ADD ADC SUB SBC AND XOR OR CP with Z80 flag rules
//--------------------------------------------------------------------------

module tv80Alu import tv80Pkg::*; (
  input  aluOp    op,
  input  dataByte operand,
  input  dataByte acc,
  input  flagSet  flagsIn,
  output dataByte result,
  output flagSet  flagsOut
);

  logic       isSub;
  logic       carryIn;
  logic [8:0] wide;     // Bit 8 is carry or borrow
  logic [4:0] nibble;   // Bit 4 is half carry or half borrow
  logic       overflow;
  dataByte    raw;

  always_comb
  begin
    isSub   = (op == aluSub) || (op == aluSbc) || (op == aluCp);
    carryIn = ((op == aluAdc) || (op == aluSbc)) ? flagsIn.c : 1'b0;

    if (isSub)
    begin
      wide     = {1'b0, acc} - {1'b0, operand} - 9'(carryIn);
      nibble   = {1'b0, acc[3:0]} - {1'b0, operand[3:0]} - 5'(carryIn);
      overflow = (acc[7] != operand[7]) && (wide[7] != acc[7]);
    end
    else
    begin
      wide     = {1'b0, acc} + {1'b0, operand} + 9'(carryIn);
      nibble   = {1'b0, acc[3:0]} + {1'b0, operand[3:0]} + 5'(carryIn);
      overflow = (acc[7] == operand[7]) && (wide[7] != acc[7]);
    end

    // Arithmetic defaults
    raw         = wide[7:0];
    flagsOut.h  = nibble[4];
    flagsOut.pv = overflow;
    flagsOut.n  = isSub;
    flagsOut.c  = wide[8];

    // Logic ops: parity in P/V, carry cleared
    case (op)
      aluAnd:
      begin
        raw         = acc & operand;
        flagsOut.h  = 1'b1;
        flagsOut.pv = ~^raw;
        flagsOut.c  = 1'b0;
      end
      aluXor:
      begin
        raw         = acc ^ operand;
        flagsOut.h  = 1'b0;
        flagsOut.pv = ~^raw;
        flagsOut.c  = 1'b0;
      end
      aluOr:
      begin
        raw         = acc | operand;
        flagsOut.h  = 1'b0;
        flagsOut.pv = ~^raw;
        flagsOut.c  = 1'b0;
      end
      default:
      begin
      end
    endcase

    flagsOut.s = raw[7];
    flagsOut.z = raw == 8'h00;
    // CP takes the undocumented bits from the operand
    flagsOut.y = (op == aluCp) ? operand[5] : raw[5];
    flagsOut.x = (op == aluCp) ? operand[3] : raw[3];

    result = (op == aluCp) ? acc : raw;   // Compare only sets flags
  end

endmodule

/* rtl/tv80Fetch.sv */
//--------------------------------------------------------------------------
// Instruction fetch unit
//   Wishbone classic master doing single-byte sequential reads
//   Pushes each returned byte with its address into the prefetch queue
//   Follows jump redirects, dropping a read that was already in flight
//--------------------------------------------------------------------------

`include "tv80_defs.svh"

module tv80Fetch import tv80Pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  output wbReq      instReq,
  input  wbRsp      instRsp,
  input  redirect   jump,
  input  logic      full,
  output logic      push,
  output queueEntry pushEntry
);

  codeAddr pc;        // Next address to read
  codeAddr reqAddr;   // Address of the outstanding read
  logic    busy;      // Read in progress, drives cyc/stb
  logic    discard;   // Outstanding read belongs to the old stream

  logic    readDone;
  logic    startRead;
  codeAddr issueAddr;

  assign readDone  = busy && instRsp.ack;
  // Queue is emptied by the redirect, so a jump may always start a read
  assign startRead = (!busy || readDone) && (!full || jump.valid);
  assign issueAddr = jump.valid ? jump.target : pc;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      busy    <= 1'b0;
      discard <= 1'b0;
      pc      <= `RESET_PC;
    end
    else
    begin
      if (startRead)
      begin
        busy <= 1'b1;
        pc   <= issueAddr + 16'd1;
      end
      else
      begin
        if (readDone)
          busy <= 1'b0;
        if (jump.valid)
          pc <= jump.target;  // Picked up once the old read ends
      end

      if (jump.valid && busy && !instRsp.ack)
        discard <= 1'b1;
      else if (readDone)
        discard <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (startRead)
      reqAddr <= issueAddr;
  end

  assign instReq   = '{cyc: busy, stb: busy, we: 1'b0, adr: reqAddr, datOut: '0};
  assign push      = readDone && !discard && !jump.valid;
  assign pushEntry = '{data: instRsp.datIn, addr: reqAddr};

endmodule

/* rtl/tv80FetchQueue.sv */
//--------------------------------------------------------------------------
// Prefetch queue between fetch and execute
//   Circular buffer with read/write pointers and an entry count
//   Flush on a taken jump, full one entry early for the read in flight
//--------------------------------------------------------------------------

`include "tv80_defs.svh"

module tv80FetchQueue import tv80Pkg::*; #(
  parameter int Depth = `QUEUE_DEPTH   // Power of two, 2 or more
) (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      push,
  input  queueEntry pushEntry,
  input  logic      flush,
  output logic      full,
  output logic      valid,
  input  logic      pop,
  output queueEntry headEntry
);

  localparam int PtrW = $clog2(Depth);

  queueEntry         store [Depth];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [PtrW:0]     count;

  logic doPush;
  logic doPop;

  assign doPush = push && !flush;
  assign doPop  = pop && valid && !flush;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else if (flush)
    begin
      rdPtr <= wrPtr;   // Drop everything still queued
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + (PtrW+1)'(doPush) - (PtrW+1)'(doPop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (doPush)
      store[wrPtr] <= pushEntry;
  end

  assign valid     = count != '0;
  assign full      = count >= (PtrW+1)'(Depth - 1);
  assign headEntry = store[rdPtr];

endmodule

/* rtl/tv80Execute.sv */
//--------------------------------------------------------------------------
// Execute unit
//   Decode FSM consuming one queue byte per cycle
//   Accumulator, flags, CPL/SCF/CCF and immediate ALU ops
//   JP / JP cc redirect, LD (nn),A and LD A,(nn) on the data Wishbone port
//--------------------------------------------------------------------------

`include "tv80_defs.svh"

module tv80Execute import tv80Pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      valid,
  output logic      pop,
  input  queueEntry headEntry,
  output redirect   jump,
  output wbReq      dataReq,
  input  wbRsp      dataRsp,
  output logic      halted
);

  execState state;
  dataByte  acc;
  flagSet   flags;
  dataByte  opcode;    // Opcode of the instruction in progress
  codeAddr  operand;   // nn, low byte first

  dataByte  aluResult;
  flagSet   aluFlags;

  logic headAluN;
  logic headNeedsAddr;
  logic condFlag;
  logic takeJump;
  logic memBusy;

  tv80Alu alu (
    .op       (aluOp'(opcode[5:3])),
    .operand  (headEntry.data),
    .acc      (acc),
    .flagsIn  (flags),
    .result   (aluResult),
    .flagsOut (aluFlags)
  );

  // Decode of the byte at the queue head
  assign headAluN      = (headEntry.data & `OP_GROUP_MASK) == `OP_ALU_N;
  assign headNeedsAddr = (headEntry.data == `OP_JP) ||
                         ((headEntry.data & `OP_GROUP_MASK) == `OP_JP_CC) ||
                         (headEntry.data == `OP_ST_A) ||
                         (headEntry.data == `OP_LD_A_MEM);

  // Condition code: NZ Z NC C PO PE P M
  always_comb
  begin
    case (opcode[5:4])
      2'b00:   condFlag = flags.z;
      2'b01:   condFlag = flags.c;
      2'b10:   condFlag = flags.pv;
      default: condFlag = flags.s;
    endcase
  end

  assign takeJump = (state == stAddrHigh) && valid &&
                    ((opcode == `OP_JP) ||
                     (((opcode & `OP_GROUP_MASK) == `OP_JP_CC) && (condFlag == opcode[3])));

  assign pop     = valid && (state inside {stOpcode, stImmediate, stAddrLow, stAddrHigh});
  assign jump    = '{valid: takeJump, target: {headEntry.data, operand[7:0]}};
  assign memBusy = (state == stMemRead) || (state == stMemWrite);
  assign dataReq = '{cyc: memBusy, stb: memBusy, we: state == stMemWrite,
                     adr: operand, datOut: acc};
  assign halted  = state == stHalted;

  //------------------------------------------------------------------------
  // Main FSM
  //------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= stOpcode;
      acc   <= `RESET_ACC;
      flags <= `RESET_FLAGS;
    end
    else
    begin
      case (state)
        stOpcode:
          if (valid)
          begin
            if (headEntry.data == `OP_HALT)
              state <= stHalted;
            else if ((headEntry.data == `OP_LD_A_N) || headAluN)
              state <= stImmediate;
            else if (headNeedsAddr)
              state <= stAddrLow;
            else if (headEntry.data == `OP_CPL)
            begin
              acc     <= ~acc;
              flags.y <= ~acc[5];
              flags.h <= 1'b1;
              flags.x <= ~acc[3];
              flags.n <= 1'b1;
            end
            else if ((headEntry.data == `OP_SCF) || (headEntry.data == `OP_CCF))
            begin
              // SCF sets C, CCF inverts it and moves the old C into H
              flags.c <= (headEntry.data == `OP_SCF) ? 1'b1 : ~flags.c;
              flags.h <= (headEntry.data == `OP_SCF) ? 1'b0 : flags.c;
              flags.y <= acc[5];
              flags.x <= acc[3];
              flags.n <= 1'b0;
            end
          end                      // Anything else runs as NOP
        stImmediate:
          if (valid)
          begin
            state <= stOpcode;
            if (opcode == `OP_LD_A_N)
              acc <= headEntry.data;
            else
            begin
              acc   <= aluResult;
              flags <= aluFlags;
            end
          end
        stAddrLow:
          if (valid)
            state <= stAddrHigh;
        stAddrHigh:
          if (valid)
          begin
            if (opcode == `OP_ST_A)
              state <= stMemWrite;
            else if (opcode == `OP_LD_A_MEM)
              state <= stMemRead;
            else
              state <= stOpcode;   // Taken or not, the jump ends here
          end
        stMemRead:
          if (dataRsp.ack)
          begin
            acc   <= dataRsp.datIn;
            state <= stOpcode;
          end
        stMemWrite:
          if (dataRsp.ack)
            state <= stOpcode;
        stHalted:
          state <= stHalted;       // Left only through reset
        default:
          state <= stOpcode;
      endcase
    end
  end

  // Instruction bytes held across states
  always_ff @(posedge clk)
  begin
    if (pop && (state == stOpcode))
      opcode <= headEntry.data;
    if (pop && (state == stAddrLow))
      operand[7:0] <= headEntry.data;
    if (pop && (state == stAddrHigh))
      operand[15:8] <= headEntry.data;
  end

endmodule

/* rtl/tv80Top.sv */
//--------------------------------------------------------------------------
// Top level of the reduced TV80 core
//   Fetch unit, prefetch queue and execute unit
//   Separate Wishbone classic instruction and data ports
//--------------------------------------------------------------------------

module tv80Top import tv80Pkg::*; (
  input  logic clk,
  input  logic reset_n,
  output wbReq instReq,
  input  wbRsp instRsp,
  output wbReq dataReq,
  input  wbRsp dataRsp,
  output logic halted
);

  logic      push;
  queueEntry pushEntry;
  logic      full;
  logic      valid;
  logic      pop;
  queueEntry headEntry;
  redirect   jump;

  tv80Fetch fetch (
    .clk       (clk),
    .reset_n   (reset_n),
    .instReq   (instReq),
    .instRsp   (instRsp),
    .jump      (jump),
    .full      (full),
    .push      (push),
    .pushEntry (pushEntry)
  );

  tv80FetchQueue queue (
    .clk       (clk),
    .reset_n   (reset_n),
    .push      (push),
    .pushEntry (pushEntry),
    .flush     (jump.valid),   // Taken jump empties the queue
    .full      (full),
    .valid     (valid),
    .pop       (pop),
    .headEntry (headEntry)
  );

  tv80Execute execute (
    .clk       (clk),
    .reset_n   (reset_n),
    .valid     (valid),
    .pop       (pop),
    .headEntry (headEntry),
    .jump      (jump),
    .dataReq   (dataReq),
    .dataRsp   (dataRsp),
    .halted    (halted)
  );

endmodule

/* tests/tv80Top_props.sv */
//--------------------------------------------------------------------------
// Bound checks on the reduced TV80 top level
//   Wishbone request stability until ack, on both ports
//   cyc equal to stb, no data request while halted
//--------------------------------------------------------------------------

module tv80TopProps import tv80Pkg::*; (
  input logic clk,
  input logic reset_n,
  input wbReq instReq,
  input wbRsp instRsp,
  input wbReq dataReq,
  input wbRsp dataRsp,
  input logic halted
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;   // Polled by the testbench

  instStable: assert property (@(posedge clk) disable iff (!reset_n)
      instReq.cyc && !instRsp.ack |=> $stable(instReq))
    else
    begin
      failCount++;
      $error("instruction request changed before ack");
    end

  dataStable: assert property (@(posedge clk) disable iff (!reset_n)
      dataReq.cyc && !dataRsp.ack |=> $stable(dataReq))
    else
    begin
      failCount++;
      $error("data request changed before ack");
    end

  cycIsStb: assert property (@(posedge clk) disable iff (!reset_n)
      (instReq.cyc == instReq.stb) && (dataReq.cyc == dataReq.stb))
    else
    begin
      failCount++;
      $error("cyc and stb differ");
    end

  haltedIdle: assert property (@(posedge clk) disable iff (!reset_n)
      halted |-> !dataReq.cyc)
    else
    begin
      failCount++;
      $error("data request while halted");
    end

endmodule

bind tv80Top tv80TopProps props (.*);

/* tests/tv80Tb.sv */
//--------------------------------------------------------------------------
// Testbench of the reduced TV80 core
//   LFSR program generator and 64 KB memory model on both ports
//   Reference interpreter producing the expected data writes
//   Comparing process, reset checks, HALT check and watchdog
//--------------------------------------------------------------------------

`include "tv80_defs.svh"

module tv80Tb import tv80Pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam codeAddr TableBase  = 16'h8000;
  localparam codeAddr ResultBase = 16'hC000;

  logic    clk = 1'b0;
  logic    reset_n;
  wbReq    instReq;
  wbRsp    instRsp;
  wbReq    dataReq;
  wbRsp    dataRsp;
  logic    halted;

  dataByte mem [0:65535];
  logic [15:0] lfsrState = 16'd47;
  codeAddr genPc;
  codeAddr resPtr;
  codeAddr expAddr [$];
  dataByte expData [$];
  string   expName [$];
  int      writeIdx = 0;
  int      cycles = 0;
  int      cycleLimit;
  int      progLen;
  int      instWait = -1;
  int      dataWait = -1;

  tv80Top i_dut (
    .clk     (clk),
    .reset_n (reset_n),
    .instReq (instReq),
    .instRsp (instRsp),
    .dataReq (dataReq),
    .dataRsp (dataRsp),
    .halted  (halted)
  );

  always #2 clk = ~clk;   // 4 ns period

  task automatic abortRun();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  //------------------------------------------------------------------------
  // Random source and program generator
  //------------------------------------------------------------------------
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int takeBits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = (v << 1) | int'(lfsrState[0]);
    end
    return v;
  endfunction

  function automatic void emitByte(input dataByte b);
    mem[genPc] = b;
    genPc = genPc + 16'd1;
  endfunction

  function automatic void emitStore();
    emitByte(`OP_ST_A);
    emitByte(resPtr[7:0]);
    emitByte(resPtr[15:8]);
    resPtr = resPtr + 16'd1;
  endfunction

  function automatic int buildProgram();
    int a;
    int blk;
    int kind;
    int sub;
    codeAddr target;
    for (a = 0; a < 65536; a++)
      mem[a] = dataByte'(a[15:8] ^ a[7:0] ^ 8'h5A);
    for (a = 0; a < 16; a++)
      mem[TableBase + codeAddr'(a)] = dataByte'(takeBits(8));
    genPc  = `RESET_PC;
    resPtr = ResultBase;
    for (blk = 0; blk < 40; blk++)
    begin
      kind = takeBits(2);
      if (kind == 2)
      begin
        target = genPc + 16'd8;           // Just past the marker store
        emitByte(`OP_JP_CC | dataByte'(takeBits(3) << 3));
        emitByte(target[7:0]);
        emitByte(target[15:8]);
        emitByte(`OP_LD_A_N);
        emitByte(dataByte'(8'h80 + blk));
        emitStore();
      end
      else if (kind == 3)
      begin
        emitByte(`OP_LD_A_MEM);
        emitByte(TableBase[7:0] + dataByte'(takeBits(4)));
        emitByte(TableBase[15:8]);
        emitStore();
      end
      else
      begin
        sub = takeBits(4);
        if (sub == 8)
          emitByte(`OP_CPL);
        else if (sub == 9)
          emitByte(`OP_SCF);
        else if (sub == 10)
          emitByte(`OP_CCF);
        else
        begin
          if (sub == 11)
            emitByte(`OP_LD_A_N);
          else
            emitByte(`OP_ALU_N | dataByte'((sub < 8 ? sub : takeBits(3)) << 3));
          emitByte(dataByte'(takeBits(8)));
        end
        emitStore();
      end
    end
    emitByte(`OP_HALT);
    return int'(genPc);
  endfunction

  //------------------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------------------
  function automatic void aluRef(input int op, input dataByte a, input dataByte b,
                                 input flagSet fin, output dataByte r, output flagSet fo);
    int      cin;
    int      sum;
    int      half;
    int      sgn;
    dataByte v;
    cin = (op == 1 || op == 3) ? int'(fin.c) : 0;
    fo  = '0;
    if (op == 0 || op == 1)
    begin
      sum  = int'(a) + int'(b) + cin;
      half = int'(a[3:0]) + int'(b[3:0]) + cin;
      sgn  = int'($signed(a)) + int'($signed(b)) + cin;
    end
    else
    begin
      sum  = int'(a) - int'(b) - cin;
      half = int'(a[3:0]) - int'(b[3:0]) - cin;
      sgn  = int'($signed(a)) - int'($signed(b)) - cin;
    end
    v     = dataByte'(sum);
    fo.c  = sum > 255 || sum < 0;
    fo.h  = half > 15 || half < 0;
    fo.pv = sgn > 127 || sgn < -128;          // Signed overflow
    fo.n  = op == 2 || op == 3 || op == 7;
    if (op >= 4 && op <= 6)
    begin
      v     = (op == 4) ? (a & b) : ((op == 5) ? (a ^ b) : (a | b));
      fo.c  = 1'b0;
      fo.h  = op == 4;
      fo.pv = ($countones(v) % 2) == 0;       // Even parity
      fo.n  = 1'b0;
    end
    fo.s = v[7];
    fo.z = v == 8'h00;
    fo.y = (op == 7) ? b[5] : v[5];
    fo.x = (op == 7) ? b[3] : v[3];
    r    = (op == 7) ? a : v;
  endfunction

  function automatic logic condMet(input logic [2:0] cc, input flagSet f);
    case (cc)
      3'd0:    return !f.z;    // NZ
      3'd1:    return f.z;
      3'd2:    return !f.c;
      3'd3:    return f.c;
      3'd4:    return !f.pv;   // PO
      3'd5:    return f.pv;
      3'd6:    return !f.s;    // P
      default: return f.s;
    endcase
  endfunction

  function automatic void buildExpected();
    codeAddr pc;
    codeAddr nn;
    dataByte a;
    dataByte op;
    flagSet  f;
    string   kind;
    int      steps;
    pc   = `RESET_PC;
    a    = `RESET_ACC;
    f    = `RESET_FLAGS;
    kind = "reset";
    for (steps = 0; steps < 4096 && mem[pc] != `OP_HALT; steps++)
    begin
      op = mem[pc];
      nn = {mem[pc + 16'd2], mem[pc + 16'd1]};
      if ((op & `OP_GROUP_MASK) == `OP_ALU_N)
      begin
        aluRef(int'(op[5:3]), a, mem[pc + 16'd1], f, a, f);
        kind = "alu";
        pc   = pc + 16'd2;
      end
      else if (op == `OP_LD_A_N)
      begin
        a    = mem[pc + 16'd1];
        kind = "ld_a_n";
        pc   = pc + 16'd2;
      end
      else if (op == `OP_CPL || op == `OP_SCF || op == `OP_CCF)
      begin
        if (op == `OP_CPL)
        begin
          a   = ~a;
          f.h = 1'b1;
          f.n = 1'b1;
        end
        else
        begin
          f.h = (op == `OP_CCF) ? f.c : 1'b0;
          f.c = (op == `OP_CCF) ? ~f.c : 1'b1;
          f.n = 1'b0;
        end
        f.y  = a[5];
        f.x  = a[3];
        kind = (op == `OP_CPL) ? "cpl" : ((op == `OP_SCF) ? "scf" : "ccf");
        pc   = pc + 16'd1;
      end
      else if (op == `OP_JP)
        pc = nn;
      else if ((op & `OP_GROUP_MASK) == `OP_JP_CC)
        pc = condMet(op[5:3], f) ? nn : pc + 16'd3;
      else if (op == `OP_ST_A)
      begin
        expAddr.push_back(nn);
        expData.push_back(a);
        expName.push_back(kind);
        pc = pc + 16'd3;
      end
      else if (op == `OP_LD_A_MEM)
      begin
        a    = mem[nn];
        kind = "ld_a_mem";
        pc   = pc + 16'd3;
      end
      else
        pc = pc + 16'd1;   // Unknown opcodes run as NOP
    end
  endfunction

  //------------------------------------------------------------------------
  // Memory model, both ports, random ack delay of 0 to 3 cycles
  //------------------------------------------------------------------------
  always
  begin
    @(posedge clk);
    #1;
    instRsp.ack = 1'b0;
    dataRsp.ack = 1'b0;
    if (reset_n && instReq.cyc && instReq.stb)
    begin
      if (instWait < 0)
        instWait = takeBits(2);       // New request
      if (instWait == 0)
      begin
        instRsp  = '{ack: 1'b1, datIn: mem[instReq.adr]};
        instWait = -1;
      end
      else
        instWait--;
    end
    if (reset_n && dataReq.cyc && dataReq.stb)
    begin
      if (dataWait < 0)
        dataWait = takeBits(2);
      if (dataWait == 0)
      begin
        dataRsp = '{ack: 1'b1, datIn: mem[dataReq.adr]};
        if (dataReq.we)
          mem[dataReq.adr] = dataReq.datOut;
        dataWait = -1;
      end
      else
        dataWait--;
    end
  end

  // Compare each data write at its ack with the next expected one
  always @(negedge clk)
  begin
    if (reset_n && dataReq.cyc && dataReq.we && dataRsp.ack)
    begin
      assert (writeIdx < expAddr.size())
      else
      begin
        $display("data write to %h after the last expected write", dataReq.adr);
        abortRun();
      end
      assert (dataReq.adr == expAddr[writeIdx] && dataReq.datOut == expData[writeIdx])
      else
      begin
        $display("error %s write %0d: expected %h at %h, actual %h at %h",
                 expName[writeIdx], writeIdx, expData[writeIdx], expAddr[writeIdx],
                 dataReq.datOut, dataReq.adr);
        abortRun();
      end
      writeIdx++;
    end
  end

  // Watchdog and bound property monitor
  always @(negedge clk)
  begin
    if (reset_n && halted !== 1'b1)
      cycles++;
    assert (cycles < cycleLimit)
    else
    begin
      $display("timeout: core not halted after %0d cycles", cycles);
      abortRun();
    end
    assert (i_dut.props.failCount == 0)
    else
    begin
      $display("a bound bus property failed");
      abortRun();
    end
  end

  //------------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------------
  initial
  begin
    int i;
    reset_n    = 1'b0;
    instRsp    = '0;
    dataRsp    = '0;
    progLen    = buildProgram();
    buildExpected();
    cycleLimit = progLen * 8 * 4 + 100;
    for (i = 0; i < 16; i++)
    begin
      @(posedge clk);
      #1;
      assert (instReq.cyc === 1'b0 && dataReq.cyc === 1'b0 && halted === 1'b0)
      else
      begin
        $display("bus cycle or halted active during reset");
        abortRun();
      end
    end
    reset_n = 1'b1;
    @(negedge clk);
    assert (instReq.cyc === 1'b0 && dataReq.cyc === 1'b0 && halted === 1'b0)
    else
    begin
      $display("bus cycle or halted active in the first cycle after reset");
      abortRun();
    end
    @(negedge clk);
    assert (instReq.cyc === 1'b1 && instReq.adr === `RESET_PC)
    else
    begin
      $display("error reset: expected first fetch at %h, actual cyc %b at %h",
               `RESET_PC, instReq.cyc, instReq.adr);
      abortRun();
    end
    while (halted !== 1'b1)
      @(negedge clk);
    assert (writeIdx == expAddr.size())
    else
    begin
      $display("halted after %0d of %0d expected writes", writeIdx, expAddr.size());
      abortRun();
    end
    repeat (40) @(negedge clk);   // A late write would reach the comparing process
    if (i_dut.props.failCount == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "bound property failures");
    end
  end

endmodule

/* all.f */
+incdir+rtl
rtl/tv80Pkg.sv
rtl/tv80Alu.sv
rtl/tv80Fetch.sv
rtl/tv80FetchQueue.sv
rtl/tv80Execute.sv
rtl/tv80Top.sv
tests/tv80Top_props.sv
tests/tv80Tb.sv

/* Bender.yml */
package:
  name: tv80_reduced

export_include_dirs:
  - rtl

sources:
  - rtl/tv80Pkg.sv
  - rtl/tv80Alu.sv
  - rtl/tv80Fetch.sv
  - rtl/tv80FetchQueue.sv
  - rtl/tv80Execute.sv
  - rtl/tv80Top.sv
  - target: test
    files:
      - tests/tv80Top_props.sv
      - tests/tv80Tb.sv
